// File: hdl/icache_pkg.sv
// Shared widths and the refill line type of the instruction cache
// Fetch address layout is tag | index | word select | byte offset
// Index and tag widths depend on N_SETS and are derived in each module
// Fetch word width must be a whole multiple of the memory beat width

package icache_pkg;

   // ------------------------------------------------------------
   // Bus widths
   // ------------------------------------------------------------
   localparam int ADDR_W         = 32;
   localparam int FETCH_W        = 64;   // One fetch word
   localparam int MEM_W          = 32;   // One memory beat
   localparam int WORDS_PER_LINE = 2;
   localparam int BEATS_PER_LINE = FETCH_W / MEM_W * WORDS_PER_LINE;
   localparam int LINE_W         = FETCH_W * WORDS_PER_LINE;
   localparam int ID_W           = 8;

   // ------------------------------------------------------------
   // Address fields
   // ------------------------------------------------------------
   localparam int BYTE_OFF_W = $clog2(FETCH_W / 8);
   localparam int WORD_SEL_W = $clog2(WORDS_PER_LINE);
   localparam int LINE_OFF_W = BYTE_OFF_W + WORD_SEL_W;   // Bits below the index

   // Refill buffer, filled beat by beat and read back word by word
   typedef union packed {
      logic [BEATS_PER_LINE-1:0][MEM_W-1:0]   beats;
      logic [WORDS_PER_LINE-1:0][FETCH_W-1:0] words;
   } line_u;

endpackage

// File: hdl/icache_tag_array.sv
// Tag store with valid bits and round-robin victim pointer per set
// Hit and way are registered on the lookup strobe and hold until the next one
// A fill writes into the way reported by the last lookup
// N_WAYS must be at least 2

`timescale 1ns/10ps

module icache_tag_array
#(
   parameter int  N_WAYS = 2,
   parameter int  N_SETS = 16,
   localparam int IDX_W  = $clog2(N_SETS),
   localparam int TAG_W  = icache_pkg::ADDR_W - icache_pkg::LINE_OFF_W - IDX_W,
   localparam int WAY_W  = $clog2(N_WAYS)
)
(
   input  logic             clk,
   input  logic             rst_n,
   input  logic             lookup_i,
   input  logic             fill_i,
   input  logic             flush_i,
   input  logic [IDX_W-1:0] index_i,
   input  logic [TAG_W-1:0] tag_i,
   output logic             hit_o,
   output logic [WAY_W-1:0] way_o     // Hit way, or victim on a miss
);

   logic [TAG_W-1:0]  tags_q  [N_SETS][N_WAYS];
   logic [N_WAYS-1:0] valid_q [N_SETS];
   logic [WAY_W-1:0]  rr_q    [N_SETS];

   logic              hit_c;
   logic [WAY_W-1:0]  hit_way_c;
   logic [WAY_W-1:0]  victim_c;

   // Parallel compare; walking down leaves the lowest invalid way as victim
   always_comb
   begin
      hit_c     = 1'b0;
      hit_way_c = '0;
      victim_c  = rr_q[index_i];
      for (int w = N_WAYS - 1; w >= 0; w--)
      begin
         if (valid_q[index_i][w] && (tags_q[index_i][w] == tag_i))
         begin
            hit_c     = 1'b1;
            hit_way_c = WAY_W'(w);
         end
         if (!valid_q[index_i][w])
            victim_c = WAY_W'(w);
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         hit_o <= 1'b0;
         way_o <= '0;
         for (int s = 0; s < N_SETS; s++)
         begin
            valid_q[s] <= '0;
            rr_q[s]    <= '0;
         end
      end
      else
      begin
         if (lookup_i)
         begin
            hit_o <= hit_c;
            way_o <= hit_c ? hit_way_c : victim_c;
         end
         if (flush_i)
         begin
            for (int s = 0; s < N_SETS; s++)
               valid_q[s] <= '0;            // Whole cache in one cycle
         end
         else if (fill_i)
         begin
            valid_q[index_i][way_o] <= 1'b1;
            rr_q[index_i] <= (rr_q[index_i] == WAY_W'(N_WAYS - 1)) ? '0 : rr_q[index_i] + 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (fill_i)
         tags_q[index_i][way_o] <= tag_i;
   end

endmodule

// File: hdl/icache_data_array.sv
// Line storage, one line per way and set
// A fill writes the whole line at its strobe edge
// A read registers one fetch word, valid the cycle after the strobe

`timescale 1ns/10ps

module icache_data_array
#(
   parameter int  N_WAYS = 2,
   parameter int  N_SETS = 16,
   localparam int IDX_W  = $clog2(N_SETS),
   localparam int WAY_W  = $clog2(N_WAYS)
)
(
   input  logic                                clk,
   input  logic                                read_i,
   input  logic                                fill_i,
   input  logic [WAY_W-1:0]                    way_i,
   input  logic [IDX_W-1:0]                    index_i,
   input  logic [icache_pkg::WORD_SEL_W-1:0]   word_sel_i,
   input  icache_pkg::line_u                   line_i,
   output logic [icache_pkg::FETCH_W-1:0]      word_o
);

   logic [icache_pkg::LINE_W-1:0] lines_q [N_WAYS][N_SETS];
   icache_pkg::line_u             rd_line;

   // ------------------------------------------------------------
   // Read side word select
   // ------------------------------------------------------------
   assign rd_line = lines_q[way_i][index_i];

   always_ff @(posedge clk)
   begin
      if (fill_i)
         lines_q[way_i][index_i] <= line_i;
      if (read_i)
         word_o <= rd_line.words[word_sel_i];   // Selected way only
   end

endmodule

// File: hdl/icache_refill.sv
// Read burst engine on the memory side
// Cache refill is a full line at the line-aligned address
// Bypass read is one fetch word at the word-aligned address
// Only one burst may be open; start must not come while busy

`timescale 1ns/10ps

module icache_refill
(
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic                               start_i,
   input  logic                               bypass_i,
   input  logic [icache_pkg::ADDR_W-1:0]      addr_i,
   // Read address channel
   output logic                               mem_ar_valid_o,
   input  logic                               mem_ar_ready_i,
   output logic [icache_pkg::ADDR_W-1:0]      mem_ar_addr_o,
   output logic [7:0]                         mem_ar_len_o,     // Beats minus one
   // Read data channel
   input  logic                               mem_r_valid_i,
   output logic                               mem_r_ready_o,
   input  logic [icache_pkg::MEM_W-1:0]       mem_r_data_i,
   input  logic                               mem_r_last_i,
   // Back to the controller
   output logic                               done_o,
   output icache_pkg::line_u                  line_o
);

   localparam int CNT_W      = $clog2(icache_pkg::BEATS_PER_LINE);
   localparam int WORD_BEATS = icache_pkg::FETCH_W / icache_pkg::MEM_W;
   localparam int OFF_B      = icache_pkg::BYTE_OFF_W;
   localparam int OFF_L      = icache_pkg::LINE_OFF_W;

   logic                          ar_valid_q;
   logic [icache_pkg::ADDR_W-1:0] ar_addr_q;
   logic [7:0]                    ar_len_q;
   logic                          open_q;
   logic                          done_q;
   logic [CNT_W-1:0]              beat_q;
   icache_pkg::line_u             line_q;
   logic [icache_pkg::ADDR_W-1:0] aligned;
   logic                          beat_ok;

   assign aligned = bypass_i ? {addr_i[icache_pkg::ADDR_W-1:OFF_B], {OFF_B{1'b0}}}
                             : {addr_i[icache_pkg::ADDR_W-1:OFF_L], {OFF_L{1'b0}}};
   assign beat_ok = open_q & mem_r_valid_i;

   // ------------------------------------------------------------
   // Burst control
   // ------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         ar_valid_q <= 1'b0;
         open_q     <= 1'b0;
         done_q     <= 1'b0;
         beat_q     <= '0;
      end
      else
      begin
         done_q <= beat_ok & mem_r_last_i;   // One cycle after the last beat
         if (start_i)
         begin
            ar_valid_q <= 1'b1;
            open_q     <= 1'b1;
            beat_q     <= '0;
         end
         else
         begin
            if (ar_valid_q && mem_ar_ready_i)
               ar_valid_q <= 1'b0;
            if (beat_ok)
            begin
               beat_q <= beat_q + 1'b1;
               if (mem_r_last_i)
                  open_q <= 1'b0;
            end
         end
      end
   end

   // Request fields and collected beats, lowest address in beat 0
   always_ff @(posedge clk)
   begin
      if (start_i)
      begin
         ar_addr_q <= aligned;
         ar_len_q  <= bypass_i ? 8'(WORD_BEATS - 1) : 8'(icache_pkg::BEATS_PER_LINE - 1);
      end
      if (beat_ok)
         line_q.beats[beat_q] <= mem_r_data_i;
   end

   assign mem_ar_valid_o = ar_valid_q;
   assign mem_ar_addr_o  = ar_addr_q;
   assign mem_ar_len_o   = ar_len_q;
   assign mem_r_ready_o  = open_q;
   assign done_o         = done_q;
   assign line_o         = line_q;

endmodule

// File: hdl/icache_ctrl.sv
// Fetch controller for grant, lookup, refill and bypass sequencing
// One fetch is in flight at a time; responses have no back-pressure
// Control requests are served only when no fetch is in flight
// Cache is disabled after reset, so fetches bypass until enabled

`timescale 1ns/10ps

module icache_ctrl
#(
   parameter int  N_WAYS = 2,
   parameter int  N_SETS = 16,
   localparam int IDX_W  = $clog2(N_SETS),
   localparam int TAG_W  = icache_pkg::ADDR_W - icache_pkg::LINE_OFF_W - IDX_W,
   localparam int WAY_W  = $clog2(N_WAYS)
)
(
   input  logic                                clk,
   input  logic                                rst_n,
   // Fetch port
   input  logic                                fetch_req_i,
   input  logic [icache_pkg::ADDR_W-1:0]       fetch_addr_i,
   input  logic [icache_pkg::ID_W-1:0]         fetch_id_i,
   output logic                                fetch_grant_o,
   output logic                                fetch_r_valid_o,
   output logic [icache_pkg::FETCH_W-1:0]      fetch_r_data_o,
   output logic [icache_pkg::ID_W-1:0]         fetch_r_id_o,
   // Control port
   input  logic                                ctrl_enable_req_i,
   input  logic                                ctrl_disable_req_i,
   input  logic                                ctrl_flush_req_i,
   output logic                                ctrl_enable_ack_o,
   output logic                                ctrl_disable_ack_o,
   output logic                                ctrl_flush_ack_o,
   output logic                                ctrl_pending_o,
   // Tag array
   output logic                                tag_lookup_o,
   output logic                                tag_fill_o,
   output logic                                tag_flush_o,
   output logic [IDX_W-1:0]                    tag_index_o,
   output logic [TAG_W-1:0]                    tag_o,
   input  logic                                tag_hit_i,
   input  logic [WAY_W-1:0]                    tag_way_i,
   // Data array
   output logic                                data_read_o,
   output logic                                data_fill_o,
   output logic [IDX_W-1:0]                    data_index_o,
   output logic [icache_pkg::WORD_SEL_W-1:0]   data_word_sel_o,
   output logic [WAY_W-1:0]                    data_way_o,
   input  logic [icache_pkg::FETCH_W-1:0]      data_word_i,
   // Refill engine
   output logic                                refill_start_o,
   output logic                                refill_bypass_o,
   output logic [icache_pkg::ADDR_W-1:0]       refill_addr_o,
   input  logic                                refill_done_i,
   input  icache_pkg::line_u                   refill_line_i
);

   localparam logic [1:0] ST_IDLE   = 2'd0;
   localparam logic [1:0] ST_LOOKUP = 2'd1;
   localparam logic [1:0] ST_REFILL = 2'd2;
   localparam logic [1:0] ST_BYPASS = 2'd3;

   logic [1:0]                            state_q;
   logic                                  enabled_q;
   logic                                  resp_q;       // Hit word arrives this cycle
   logic                                  flush_ack_q;
   logic [icache_pkg::ADDR_W-1:0]         addr_q;
   logic [icache_pkg::ID_W-1:0]           id_q;
   logic [icache_pkg::ADDR_W-1:0]         cur_addr;
   logic [icache_pkg::WORD_SEL_W-1:0]     word_sel;
   logic                                  free;
   logic                                  grant;

   // ------------------------------------------------------------
   // Handshakes
   // ------------------------------------------------------------
   assign free  = (state_q == ST_IDLE) & ~resp_q & ~flush_ack_q;
   assign grant = free & fetch_req_i &
                  ~(ctrl_enable_req_i | ctrl_disable_req_i | ctrl_flush_req_i);

   assign ctrl_enable_ack_o  = free & ctrl_enable_req_i;
   assign ctrl_disable_ack_o = free & ctrl_disable_req_i & ~ctrl_enable_req_i;
   assign tag_flush_o        = free & ctrl_flush_req_i & ~ctrl_enable_req_i & ~ctrl_disable_req_i;
   assign ctrl_flush_ack_o   = flush_ack_q;
   assign ctrl_pending_o     = (state_q != ST_IDLE) | resp_q;

   // Lookup uses the live request address, everything later the held one
   assign cur_addr = (state_q == ST_IDLE) ? fetch_addr_i : addr_q;
   assign word_sel = addr_q[icache_pkg::BYTE_OFF_W +: icache_pkg::WORD_SEL_W];

   assign tag_lookup_o    = grant & enabled_q;
   assign tag_fill_o      = (state_q == ST_REFILL) & refill_done_i;
   assign tag_index_o     = cur_addr[icache_pkg::LINE_OFF_W +: IDX_W];
   assign tag_o           = cur_addr[icache_pkg::ADDR_W-1 -: TAG_W];
   assign data_read_o     = (state_q == ST_LOOKUP) & tag_hit_i;
   assign data_fill_o     = tag_fill_o;
   assign data_index_o    = addr_q[icache_pkg::LINE_OFF_W +: IDX_W];
   assign data_word_sel_o = word_sel;
   assign data_way_o      = tag_way_i;                     // Hit way or victim
   assign refill_start_o  = (grant & ~enabled_q) | ((state_q == ST_LOOKUP) & ~tag_hit_i);
   assign refill_bypass_o = ~enabled_q;
   assign refill_addr_o   = cur_addr;

   assign fetch_grant_o   = grant;
   assign fetch_r_valid_o = resp_q | refill_done_i;
   assign fetch_r_id_o    = id_q;
   assign fetch_r_data_o  = resp_q                 ? data_word_i :
                            (state_q == ST_BYPASS) ? refill_line_i.words[0] :
                                                     refill_line_i.words[word_sel];

   // ------------------------------------------------------------
   // State machine and mode
   // ------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q     <= ST_IDLE;
         enabled_q   <= 1'b0;
         resp_q      <= 1'b0;
         flush_ack_q <= 1'b0;
      end
      else
      begin
         resp_q      <= data_read_o;
         flush_ack_q <= tag_flush_o;   // Valid bits are clear by now
         if (ctrl_enable_ack_o)
            enabled_q <= 1'b1;
         else if (ctrl_disable_ack_o)
            enabled_q <= 1'b0;
         case (state_q)
            ST_IDLE:   if (grant) state_q <= enabled_q ? ST_LOOKUP : ST_BYPASS;
            ST_LOOKUP: state_q <= tag_hit_i ? ST_IDLE : ST_REFILL;
            ST_REFILL,
            ST_BYPASS: if (refill_done_i) state_q <= ST_IDLE;
            default:   state_q <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (grant)
      begin
         addr_q <= fetch_addr_i;
         id_q   <= fetch_id_i;
      end
   end

endmodule

// File: hdl/icache_top.sv
// Set-associative instruction cache with a read-only burst port
// Geometry is set by N_WAYS (2 or more) and N_SETS (a power of two)
// Starts disabled; every fetch bypasses until an enable is acknowledged

`timescale 1ns/10ps

module icache_top
#(
   parameter int  N_WAYS = 2,
   parameter int  N_SETS = 16,
   localparam int IDX_W  = $clog2(N_SETS),
   localparam int TAG_W  = icache_pkg::ADDR_W - icache_pkg::LINE_OFF_W - IDX_W,
   localparam int WAY_W  = $clog2(N_WAYS)
)
(
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             fetch_req_i,
   input  logic [icache_pkg::ADDR_W-1:0]    fetch_addr_i,
   input  logic [icache_pkg::ID_W-1:0]      fetch_id_i,
   output logic                             fetch_grant_o,
   output logic                             fetch_r_valid_o,
   output logic [icache_pkg::FETCH_W-1:0]   fetch_r_data_o,
   output logic [icache_pkg::ID_W-1:0]      fetch_r_id_o,
   output logic                             mem_ar_valid_o,
   input  logic                             mem_ar_ready_i,
   output logic [icache_pkg::ADDR_W-1:0]    mem_ar_addr_o,
   output logic [7:0]                       mem_ar_len_o,
   input  logic                             mem_r_valid_i,
   output logic                             mem_r_ready_o,
   input  logic [icache_pkg::MEM_W-1:0]     mem_r_data_i,
   input  logic                             mem_r_last_i,
   input  logic                             ctrl_enable_req_i,
   output logic                             ctrl_enable_ack_o,
   input  logic                             ctrl_disable_req_i,
   output logic                             ctrl_disable_ack_o,
   input  logic                             ctrl_flush_req_i,
   output logic                             ctrl_flush_ack_o,
   output logic                             ctrl_pending_o
);

   logic                                tag_lookup, tag_fill, tag_flush, tag_hit;
   logic [IDX_W-1:0]                    tag_index, data_index;
   logic [TAG_W-1:0]                    tag;
   logic [WAY_W-1:0]                    tag_way, data_way;
   logic                                data_read, data_fill;
   logic [icache_pkg::WORD_SEL_W-1:0]   data_word_sel;
   logic [icache_pkg::FETCH_W-1:0]      data_word;
   logic                                refill_start, refill_bypass, refill_done;
   logic [icache_pkg::ADDR_W-1:0]       refill_addr;
   icache_pkg::line_u                   refill_line;

   icache_ctrl #(.N_WAYS(N_WAYS), .N_SETS(N_SETS)) u_ctrl (
      .clk, .rst_n,
      .fetch_req_i, .fetch_addr_i, .fetch_id_i, .fetch_grant_o,
      .fetch_r_valid_o, .fetch_r_data_o, .fetch_r_id_o,
      .ctrl_enable_req_i, .ctrl_disable_req_i, .ctrl_flush_req_i,
      .ctrl_enable_ack_o, .ctrl_disable_ack_o, .ctrl_flush_ack_o, .ctrl_pending_o,
      .tag_lookup_o    (tag_lookup),     .tag_fill_o      (tag_fill),
      .tag_flush_o     (tag_flush),      .tag_index_o     (tag_index),
      .tag_o           (tag),            .tag_hit_i       (tag_hit),
      .tag_way_i       (tag_way),        .data_read_o     (data_read),
      .data_fill_o     (data_fill),      .data_index_o    (data_index),
      .data_word_sel_o (data_word_sel),  .data_way_o      (data_way),
      .data_word_i     (data_word),      .refill_start_o  (refill_start),
      .refill_bypass_o (refill_bypass),  .refill_addr_o   (refill_addr),
      .refill_done_i   (refill_done),    .refill_line_i   (refill_line)
   );

   icache_tag_array #(.N_WAYS(N_WAYS), .N_SETS(N_SETS)) u_tags (
      .clk, .rst_n,
      .lookup_i (tag_lookup), .fill_i  (tag_fill), .flush_i (tag_flush),
      .index_i  (tag_index),  .tag_i   (tag),
      .hit_o    (tag_hit),    .way_o   (tag_way)
   );

   icache_data_array #(.N_WAYS(N_WAYS), .N_SETS(N_SETS)) u_data (
      .clk,
      .read_i     (data_read),     .fill_i  (data_fill),  .way_i  (data_way),
      .index_i    (data_index),    .line_i  (refill_line),
      .word_sel_i (data_word_sel), .word_o  (data_word)
   );

   icache_refill u_refill (
      .clk, .rst_n,
      .start_i  (refill_start), .bypass_i (refill_bypass), .addr_i (refill_addr),
      .mem_ar_valid_o, .mem_ar_ready_i, .mem_ar_addr_o, .mem_ar_len_o,
      .mem_r_valid_i, .mem_r_ready_o, .mem_r_data_i, .mem_r_last_i,
      .done_o   (refill_done),  .line_o   (refill_line)
   );

endmodule

// File: sim/icache_mem_model.sv
// Read-only burst responder for the cache memory port
// Beat data is its byte address XOR PATTERN, one word address per beat
// Serves one burst at a time; stalls come from $urandom seeded by the testbench

`timescale 1ns/10ps

module icache_mem_model
#(
   parameter logic [31:0] PATTERN = 32'h0
)
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        ar_valid_i,
   output logic        ar_ready_o,
   input  logic [31:0] ar_addr_i,
   input  logic [7:0]  ar_len_i,
   output logic        r_valid_o,
   input  logic        r_ready_i,
   output logic [31:0] r_data_o,
   output logic        r_last_o
);

   logic        busy_q;
   logic [31:0] addr_q;   // Address of the beat on offer
   logic [7:0]  len_q;
   logic [7:0]  cnt_q;

   assign r_data_o = addr_q ^ PATTERN;
   assign r_last_o = (cnt_q == len_q);

   always @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         ar_ready_o <= 1'b0;
         r_valid_o  <= 1'b0;
         busy_q     <= 1'b0;
         addr_q     <= '0;
         len_q      <= '0;
         cnt_q      <= '0;
      end
      else if (!busy_q)
      begin
         if (ar_valid_i && ar_ready_o)
         begin
            busy_q     <= 1'b1;
            addr_q     <= ar_addr_i;
            len_q      <= ar_len_i;
            cnt_q      <= '0;
            ar_ready_o <= 1'b0;
         end
         else
            ar_ready_o <= ($urandom % 4) != 0;   // Random address stall
      end
      else if (r_valid_o && r_ready_i)
      begin
         addr_q    <= addr_q + 32'd4;
         cnt_q     <= cnt_q + 8'd1;
         r_valid_o <= !r_last_o && (($urandom % 4) != 0);
         if (r_last_o)
            busy_q <= 1'b0;
      end
      else if (!r_valid_o)
         r_valid_o <= ($urandom % 4) != 0;      // Valid holds once raised
   end

endmodule

// File: sim/icache_tb.sv
// Testbench for the instruction cache top level
// Operations come from sim/icache_cases.txt, so run from the project root
// Eviction cases assume the default geometry of 2 ways and 16 sets
// Memory stalls are random with a fixed seed

`timescale 1ns/10ps

module icache_tb;

   localparam logic [31:0] PATTERN = 32'hc0de_0000;   // Memory beat is address XOR this
   localparam int          LIMIT   = 300;             // Edges allowed for any wait
   localparam int          MAX_OPS = 64;

   logic        clk;
   logic        rst_n;
   logic        fetch_req, fetch_grant, fetch_r_valid;
   logic [31:0] fetch_addr;
   logic [7:0]  fetch_id, fetch_r_id;
   logic [63:0] fetch_r_data;
   logic        mem_ar_valid, mem_ar_ready, mem_r_valid, mem_r_ready, mem_r_last;
   logic [31:0] mem_ar_addr, mem_r_data;
   logic [7:0]  mem_ar_len;
   logic        enable_req, disable_req, flush_req;
   logic        enable_ack, disable_ack, flush_ack, pending;

   logic [31:0] cases_mem [0:4*MAX_OPS-1];   // Kind, address, ID, refill per operation
   int          ar_count;
   logic [31:0] ar_addr_seen;
   logic [7:0]  ar_len_seen;
   logic        in_flight;                   // Set from grant until response
   logic        enabled;                     // Mode the cache should be in
   int          op;

   initial clk = 1'b0;
   always #2 clk = ~clk;

   icache_top #(.N_WAYS(2), .N_SETS(16)) dut_i (
      .clk, .rst_n,
      .fetch_req_i        (fetch_req),    .fetch_addr_i      (fetch_addr),
      .fetch_id_i         (fetch_id),     .fetch_grant_o     (fetch_grant),
      .fetch_r_valid_o    (fetch_r_valid), .fetch_r_data_o   (fetch_r_data),
      .fetch_r_id_o       (fetch_r_id),
      .mem_ar_valid_o     (mem_ar_valid), .mem_ar_ready_i    (mem_ar_ready),
      .mem_ar_addr_o      (mem_ar_addr),  .mem_ar_len_o      (mem_ar_len),
      .mem_r_valid_i      (mem_r_valid),  .mem_r_ready_o     (mem_r_ready),
      .mem_r_data_i       (mem_r_data),   .mem_r_last_i      (mem_r_last),
      .ctrl_enable_req_i  (enable_req),   .ctrl_enable_ack_o (enable_ack),
      .ctrl_disable_req_i (disable_req),  .ctrl_disable_ack_o (disable_ack),
      .ctrl_flush_req_i   (flush_req),    .ctrl_flush_ack_o  (flush_ack),
      .ctrl_pending_o     (pending)
   );

   icache_mem_model #(.PATTERN(PATTERN)) mem_i (
      .clk, .rst_n,
      .ar_valid_i (mem_ar_valid), .ar_ready_o (mem_ar_ready),
      .ar_addr_i  (mem_ar_addr),  .ar_len_i   (mem_ar_len),
      .r_valid_o  (mem_r_valid),  .r_ready_i  (mem_r_ready),
      .r_data_o   (mem_r_data),   .r_last_o   (mem_r_last)
   );

   // ------------------------------------------------------------
   // Failure reporting
   // ------------------------------------------------------------
   task automatic fail_run();
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic compare(input string name, input logic [63:0] expected,
                          input logic [63:0] actual);
      if (expected !== actual)
      begin
         $display("error %s expected %h actual %h", name, expected, actual);
         fail_run();
      end
   endtask

   // Read requests and the pending flag sampled on every edge
   always @(posedge clk)
   begin
      if (!rst_n)
      begin
         ar_count     <= 0;
         ar_addr_seen <= '0;
         ar_len_seen  <= '0;
         in_flight    <= 1'b0;
      end
      else
      begin
         if (mem_ar_valid && mem_ar_ready)
         begin
            ar_count     <= ar_count + 1;
            ar_addr_seen <= mem_ar_addr;
            ar_len_seen  <= mem_ar_len;
         end
         compare("pending flag", 64'(in_flight), 64'(pending));
         if (!in_flight)
            compare("read ready while idle", 64'd0, 64'(mem_r_ready));
         if (fetch_grant)
            in_flight <= 1'b1;
         else if (fetch_r_valid)
            in_flight <= 1'b0;
      end
   end

   // ------------------------------------------------------------
   // Operations
   // ------------------------------------------------------------
   task automatic request_control(input logic [31:0] kind, input int op_num);
      int         n;
      logic [2:0] expected;
      string      name;
      name     = $sformatf("op %0d control %0d", op_num, kind);
      expected = (kind == 32'd2) ? 3'b100 : (kind == 32'd3) ? 3'b010 : 3'b001;
      enable_req  <= (kind == 32'd2);
      disable_req <= (kind == 32'd3);
      flush_req   <= (kind == 32'd4);
      n = 0;
      do
      begin
         @(posedge clk);
         n++;
      end
      while (!(enable_ack || disable_ack || flush_ack) && n < LIMIT);
      if (!(enable_ack || disable_ack || flush_ack))
      begin
         $display("no acknowledge arrived for %s", name);
         fail_run();
      end
      compare({name, " ack"}, 64'(expected), 64'({enable_ack, disable_ack, flush_ack}));
      enable_req  <= 1'b0;
      disable_req <= 1'b0;
      flush_req   <= 1'b0;
      if (kind != 32'd4)
         enabled = (kind == 32'd2);
   endtask

   task automatic run_fetch(input logic [31:0] addr, input logic [7:0] id,
                            input logic refill, input int op_num);
      int          n;
      int          reads;
      logic [31:0] word_addr;
      logic [63:0] expected;
      string       name;
      name      = $sformatf("op %0d fetch %h", op_num, addr);
      word_addr = {addr[31:3], 3'b000};
      expected  = {(word_addr + 32'd4) ^ PATTERN, word_addr ^ PATTERN};   // Low address low half
      reads     = ar_count;
      fetch_req  <= 1'b1;
      fetch_addr <= addr;
      fetch_id   <= id;
      n = 0;
      do
      begin
         @(posedge clk);
         n++;
      end
      while (!fetch_grant && n < LIMIT);
      if (!fetch_grant)
      begin
         $display("fetch was never granted for %s", name);
         fail_run();
      end
      fetch_req <= 1'b0;
      n = 0;
      do
      begin
         @(posedge clk);
         n++;
      end
      while (!fetch_r_valid && n < LIMIT);
      if (!fetch_r_valid)
      begin
         $display("no fetch response arrived for %s", name);
         fail_run();
      end
      compare({name, " data"}, expected, fetch_r_data);
      compare({name, " id"}, 64'(id), 64'(fetch_r_id));
      compare({name, " reads"}, 64'(refill), 64'(ar_count - reads));
      if (refill)
      begin
         compare({name, " length"}, enabled ? 64'd3 : 64'd1, 64'(ar_len_seen));
         compare({name, " address"}, enabled ? 64'({addr[31:4], 4'h0}) : 64'(word_addr),
                 64'(ar_addr_seen));
      end
      else
         compare({name, " hit latency"}, 64'd2, 64'(n));
   endtask

   initial
   begin
      void'($urandom(32'h1757_4cf6));
      rst_n       <= 1'b0;
      fetch_req   <= 1'b0;
      fetch_addr  <= '0;
      fetch_id    <= '0;
      enable_req  <= 1'b0;
      disable_req <= 1'b0;
      flush_req   <= 1'b0;
      enabled = 1'b0;                  // Disabled out of reset
      $readmemh("sim/icache_cases.txt", cases_mem);
      if ($isunknown(cases_mem[0]))
      begin
         $display("cases file sim/icache_cases.txt could not be read");
         fail_run();
      end
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      op = 0;
      while (op < MAX_OPS && cases_mem[4*op] != 32'd0)
      begin
         case (cases_mem[4*op])
            32'd1:   run_fetch(cases_mem[4*op+1], cases_mem[4*op+2][7:0],
                               cases_mem[4*op+3][0], op);
            32'd2,
            32'd3,
            32'd4:   request_control(cases_mem[4*op], op);
            default:
            begin
               $display("unknown operation kind in the cases file at op %0d", op);
               fail_run();
            end
         endcase
         op++;
      end
      repeat (3) @(posedge clk);
      $display("TEST OK");
      $finish;
   end

endmodule

// File: sim/icache_cases.txt
// Columns: kind address id refill, all hex; one operation per line
// Kind 1 fetch, 2 enable, 3 disable, 4 flush, 0 ends the list
1 00000100 01 1
1 00000108 02 1
1 00000100 03 1
2 00000000 00 0
1 00000200 04 1
1 00000208 05 0
1 00000200 06 0
// Three lines in set 3, the third evicts the first
1 00001030 07 1
1 00002030 08 1
1 00003030 09 1
1 00001038 0a 1
1 00003038 0b 0
4 00000000 00 0
1 00000208 0c 1
1 00000200 0d 0
3 00000000 00 0
1 00000200 0e 1
0 00000000 00 0

// File: build.f
hdl/icache_pkg.sv
hdl/icache_tag_array.sv
hdl/icache_data_array.sv
hdl/icache_refill.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
sim/icache_mem_model.sv
sim/icache_tb.sv

// File: Makefile
# Verilator flow for the instruction cache testbench
TOP = icache_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f build.f --top-module $(TOP) \
		-Mdir obj_dir -o icache_sim
	./obj_dir/icache_sim | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
